// ==== logic/configRegisters.sv ====
`timescale 1ns/10ps
`default_nettype none

module configRegisters (
    input  wire logic              Clk,
    input  wire logic              rstN,
    input  wire logic              cmdValid,
    input  wire daqPkg::cmdWordT   cmdWord,
    input  wire logic              scBusy,     // From shifter
    output logic                   cmdReady,
    output daqPkg::daqConfigT      daqConfig,
    output logic                   scLoad      // One cycle, starts the shifter
);
    import daqPkg::*;

    cmdAddrT cmdAddr;
    cmdDataT cmdData;
    logic    cmdAccept;

    // Word split
    assign cmdAddr = cmdWord[CMD_WORD_BITS-1 -: CMD_ADDR_BITS];
    assign cmdData = cmdWord[CMD_DATA_BITS-1:0];

    // Host stalls while a shift runs
    assign cmdReady  = ~scBusy;
    assign cmdAccept = cmdValid & cmdReady;     // Transfer on this edge

    //////////////////////////////////////////////////////////////////////
    // Field decode
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            daqConfig <= CONFIG_RESET;
        end else if (cmdAccept) begin
            case (cmdAddr)
                ADDR_DAC0:       daqConfig.dac0      <= cmdData[DAC_BITS-1:0];
                ADDR_DAC1:       daqConfig.dac1      <= cmdData[DAC_BITS-1:0];
                ADDR_DAC2:       daqConfig.dac2      <= cmdData[DAC_BITS-1:0];
                ADDR_HEADER:     daqConfig.header    <= cmdData[HEADER_BITS-1:0];
                ADDR_TRIG_MODE: begin
                    daqConfig.trigMode <= trigModeT'(cmdData[$bits(trigModeT)-1:0]);
                end
                ADDR_HOLD_EN:    daqConfig.holdEn    <= cmdData[0];
                ADDR_HOLD_DELAY: daqConfig.holdDelay <= cmdData[HOLD_DELAY_BITS-1:0];
                ADDR_HOLD_TIME:  daqConfig.holdTime  <= cmdData[HOLD_TIME_BITS-1:0];
                default: begin
                    // Load and unused addresses leave the fields alone
                end
            endcase
        end
    end

    // Load strobe, one cycle after the accepted load word
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            scLoad <= 1'b0;
        end else begin
            scLoad <= cmdAccept && (cmdAddr == ADDR_LOAD);
        end
    end

endmodule

`default_nettype wire

// ==== logic/daqPkg.sv ====
`default_nettype none

package daqPkg;

    //////////////////////////////////////////////////////////////////////
    // Field widths
    //////////////////////////////////////////////////////////////////////
    localparam int CMD_ADDR_BITS   = 4;
    localparam int CMD_DATA_BITS   = 12;
    localparam int CMD_WORD_BITS   = CMD_ADDR_BITS + CMD_DATA_BITS;
    localparam int DAC_BITS        = 10;
    localparam int HEADER_BITS     = 8;
    localparam int HOLD_DELAY_BITS = 8;
    localparam int HOLD_TIME_BITS  = 12;
    localparam int SC_WORD_BITS    = 38;                    // Header plus three DACs
    localparam int SC_CNT_BITS     = $clog2(SC_WORD_BITS);
    localparam int SYNC_STAGES     = 2;                     // Trigger synchronizer depth

    typedef logic [CMD_WORD_BITS-1:0]   cmdWordT;           // Address on top, data below
    typedef logic [CMD_ADDR_BITS-1:0]   cmdAddrT;
    typedef logic [CMD_DATA_BITS-1:0]   cmdDataT;
    typedef logic [DAC_BITS-1:0]        dacCodeT;           // Threshold DAC code
    typedef logic [HEADER_BITS-1:0]     headerT;
    typedef logic [HOLD_DELAY_BITS-1:0] holdDelayT;         // Clock cycles
    typedef logic [HOLD_TIME_BITS-1:0]  holdTimeT;          // Clock cycles
    typedef logic [SC_WORD_BITS-1:0]    scWordT;            // Sent MSB first
    typedef logic [SC_CNT_BITS-1:0]     scBitCntT;

    // Command addresses
    localparam cmdAddrT ADDR_DAC0       = 4'd1;
    localparam cmdAddrT ADDR_DAC1       = 4'd2;
    localparam cmdAddrT ADDR_DAC2       = 4'd3;
    localparam cmdAddrT ADDR_HEADER     = 4'd4;
    localparam cmdAddrT ADDR_TRIG_MODE  = 4'd5;
    localparam cmdAddrT ADDR_HOLD_EN    = 4'd6;
    localparam cmdAddrT ADDR_HOLD_DELAY = 4'd7;
    localparam cmdAddrT ADDR_HOLD_TIME  = 4'd8;
    localparam cmdAddrT ADDR_LOAD       = 4'd9;             // Starts a slow control shift

    //////////////////////////////////////////////////////////////////////
    // State machines and configuration
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        trigSingle   = 2'd0,    // Trigger 0 only
        trigOr       = 2'd1,
        trigAnd      = 2'd2,
        trigExternal = 2'd3
    } trigModeT;

    // Gray order, so the srCk decode never glitches
    typedef enum logic [1:0] {
        scIdle      = 2'b00,
        scShiftLow  = 2'b01,
        scShiftHigh = 2'b11,
        scDone      = 2'b10
    } scStateT;

    typedef enum logic [1:0] {
        hgIdle,
        hgDelay,
        hgHolding
    } holdStateT;

    typedef struct packed {
        dacCodeT   dac0;
        dacCodeT   dac1;
        dacCodeT   dac2;
        headerT    header;
        trigModeT  trigMode;
        logic      holdEn;
        holdDelayT holdDelay;
        holdTimeT  holdTime;
    } daqConfigT;

    localparam daqConfigT CONFIG_RESET = '{
        dac0: '0, dac1: '0, dac2: '0, header: '0,
        trigMode: trigOr, holdEn: 1'b0, holdDelay: '0, holdTime: '0
    };

endpackage

`default_nettype wire

// ==== logic/daqTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module daqTop (
    input  wire logic             Clk,
    input  wire logic             rstN,
    // Host command stream
    input  wire logic             cmdValid,
    input  wire daqPkg::cmdWordT  cmdWord,
    output wire logic             cmdReady,
    // ASIC pins
    input  wire logic [2:0]       outTrigB,
    input  wire logic             extTrigB,
    output wire logic             srCk,
    output wire logic             srIn,
    output wire logic             hold,
    // Status
    output wire logic             configDone,
    output wire logic             trigOut
);
    import daqPkg::*;

    wire daqConfigT daqConfig;  // Decoded fields to all blocks
    wire logic      scLoad;
    wire logic      scBusy;

    configRegisters regs (
        .Clk       (Clk),
        .rstN      (rstN),
        .cmdValid  (cmdValid),
        .cmdWord   (cmdWord),
        .scBusy    (scBusy),
        .cmdReady  (cmdReady),
        .daqConfig (daqConfig),
        .scLoad    (scLoad)
    );

    slowControlShifter shifter (
        .Clk        (Clk),
        .rstN       (rstN),
        .scLoad     (scLoad),
        .daqConfig  (daqConfig),
        .scBusy     (scBusy),       // Back to register block for stalling
        .srCk       (srCk),
        .srIn       (srIn),
        .configDone (configDone)
    );

    triggerCoincidence trigSelect (
        .Clk       (Clk),
        .rstN      (rstN),
        .outTrigB  (outTrigB),
        .extTrigB  (extTrigB),
        .trigMode  (daqConfig.trigMode),
        .trigPulse (trigOut)
    );

    holdGenerator holdGen (
        .Clk       (Clk),
        .rstN      (rstN),
        .trigPulse (trigOut),
        .holdEn    (daqConfig.holdEn),
        .holdDelay (daqConfig.holdDelay),
        .holdTime  (daqConfig.holdTime),
        .hold      (hold)
    );

endmodule

`default_nettype wire

// ==== logic/holdGenerator.sv ====
`timescale 1ns/10ps
`default_nettype none

module holdGenerator (
    input  wire logic               Clk,
    input  wire logic               rstN,
    input  wire logic               trigPulse,
    input  wire logic               holdEn,
    input  wire daqPkg::holdDelayT  holdDelay,
    input  wire daqPkg::holdTimeT   holdTime,
    output logic                    hold
);
    import daqPkg::*;

    holdStateT state;
    holdTimeT  count;       // Shared by delay and width phases
    logic      trigAccept;

    // Zero width means no hold at all
    assign trigAccept = trigPulse && holdEn && (holdTime != '0);

    //////////////////////////////////////////////////////////////////////
    // Delay then width, retriggers ignored until idle
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state <= hgIdle;
            count <= '0;
            hold  <= 1'b0;
        end else begin
            case (state)
                hgIdle: begin
                    if (trigAccept && (holdDelay == '0)) begin
                        state <= hgHolding;         // Hold right after the pulse
                        count <= holdTime - 1'b1;
                        hold  <= 1'b1;
                    end else if (trigAccept) begin
                        state <= hgDelay;
                        count <= holdTimeT'(holdDelay) - 1'b1;
                    end
                end
                hgDelay: begin
                    if (count == '0) begin
                        state <= hgHolding;
                        count <= holdTime - 1'b1;
                        hold  <= 1'b1;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                hgHolding: begin
                    if (count == '0) begin
                        state <= hgIdle;            // Width done
                        hold  <= 1'b0;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: begin
                    state <= hgIdle;
                    hold  <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/slowControlShifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module slowControlShifter (
    input  wire logic               Clk,
    input  wire logic               rstN,
    input  wire logic               scLoad,
    input  wire daqPkg::daqConfigT  daqConfig,
    output logic                    scBusy,
    output logic                    srCk,       // ASIC samples on rising edge
    output logic                    srIn,
    output logic                    configDone  // One cycle after last bit
);
    import daqPkg::*;

    scStateT  state;
    scBitCntT bitCnt;       // Bits still to go after the current one
    scWordT   shiftReg;
    scWordT   paramWord;
    logic     loadStart;

    // ASIC parameter order, header first
    assign paramWord = {daqConfig.header, daqConfig.dac2, daqConfig.dac1, daqConfig.dac0};

    assign loadStart = (state == scIdle) && scLoad;   // Ignored unless idle

    //////////////////////////////////////////////////////////////////////
    // Bit sequencer
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            state  <= scIdle;
            bitCnt <= '0;
        end else begin
            case (state)
                scIdle: begin
                    if (scLoad) begin
                        state  <= scShiftLow;
                        bitCnt <= scBitCntT'(SC_WORD_BITS - 1);
                    end
                end
                scShiftLow: begin
                    state <= scShiftHigh;       // Data settled, raise clock
                end
                scShiftHigh: begin
                    if (bitCnt == '0) begin
                        state <= scDone;        // 38th high phase over
                    end else begin
                        state  <= scShiftLow;
                        bitCnt <= bitCnt - 1'b1;
                    end
                end
                scDone: begin
                    state <= scIdle;
                end
                default: begin
                    state <= scIdle;
                end
            endcase
        end
    end

    // Word captured on load, advanced after each high phase
    always_ff @(posedge Clk) begin
        if (loadStart) begin
            shiftReg <= paramWord;
        end else if (state == scShiftHigh) begin
            shiftReg <= {shiftReg[SC_WORD_BITS-2:0], 1'b0};
        end
    end

    // Pin decode
    assign scBusy     = (state == scShiftLow) || (state == scShiftHigh);
    assign srCk       = (state == scShiftHigh);
    assign srIn       = scBusy & shiftReg[SC_WORD_BITS-1];   // Low outside a shift
    assign configDone = (state == scDone);

endmodule

`default_nettype wire

// ==== logic/triggerCoincidence.sv ====
`timescale 1ns/10ps
`default_nettype none

module triggerCoincidence (
    input  wire logic              Clk,
    input  wire logic              rstN,
    input  wire logic [2:0]        outTrigB,   // ASIC triggers, active low
    input  wire logic              extTrigB,   // External pin, active low
    input  wire daqPkg::trigModeT  trigMode,
    output logic                   trigPulse
);
    import daqPkg::*;

    logic [SYNC_STAGES-1:0][3:0] syncChain;    // Bit 3 external, bits 2..0 ASIC
    logic [3:0]                  trigSync;
    logic                        trigSel;
    logic                        trigSelPrev;

    // Synchronizer, inverted at the first stage so 1 means fired
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            syncChain <= '0;
        end else begin
            syncChain <= {syncChain[SYNC_STAGES-2:0], ~{extTrigB, outTrigB}};
        end
    end

    assign trigSync = syncChain[SYNC_STAGES-1];

    // Coincidence select
    always_comb begin
        case (trigMode)
            trigSingle:   trigSel = trigSync[0];
            trigOr:       trigSel = |trigSync[2:0];
            trigAnd:      trigSel = &trigSync[2:0];
            trigExternal: trigSel = trigSync[3];
            default:      trigSel = 1'b0;
        endcase
    end

    // Rising edge of the selection, one cycle wide
    always_ff @(posedge Clk) begin
        if (!rstN) begin
            trigSelPrev <= 1'b0;
            trigPulse   <= 1'b0;
        end else begin
            trigSelPrev <= trigSel;
            trigPulse   <= trigSel & ~trigSelPrev;
        end
    end

endmodule

`default_nettype wire

// ==== project.f ====
logic/daqPkg.sv
logic/configRegisters.sv
logic/slowControlShifter.sv
logic/triggerCoincidence.sv
logic/holdGenerator.sv
logic/daqTop.sv
testbench/clockGen.sv
testbench/daqTopTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, judge by its closing line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/10ps -f project.f \
    --top-module daqTopTb -Mdir obj_dir -o daqTopSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/daqTopSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "^Done: no errors$"; then
    exit 0
fi
exit 1

// ==== testbench/clockGen.sv ====
`timescale 1ns/10ps
`default_nettype none

module clockGen (
    output logic Clk,
    output logic rstN
);

    // 8 ns period
    initial begin
        Clk = 1'b0;
        forever #4 Clk = ~Clk;
    end

    // Low for the first two rising edges
    initial begin
        rstN = 1'b0;
        repeat (2) @(posedge Clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== testbench/daqTopTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module daqTopTb;
    import daqPkg::*;

    // {extTrigB, outTrigB}, active low, each applied from the idle level
    localparam logic [3:0] TRIG_PATTERNS [0:5] = '{
        4'b1110, 4'b1101, 4'b1011, 4'b1000, 4'b0111, 4'b0000
    };

    logic        Clk;
    logic        rstN;
    logic        cmdValid;
    cmdWordT     cmdWord;
    logic        cmdReady;
    logic [2:0]  outTrigB;
    logic        extTrigB;
    logic        srCk;
    logic        srIn;
    logic        configDone;
    logic        trigOut;
    logic        hold;

    logic [63:0] cycle = '0;        // Rising edges seen so far
    int          errorCount = 0;
    int          testStartErrors = 0;
    int          testCount = 0;
    int          failedTests = 0;
    string       curTest = "init";
    scWordT      expWord = '0;      // Word the next configDone must carry
    scWordT      capWord = '0;
    logic [63:0] srCkEdges = '0;
    logic [63:0] doneCount = '0;
    logic        srCkPrev = 1'b0;

    clockGen clocks (.Clk(Clk), .rstN(rstN));

    daqTop DUT (
        .Clk        (Clk),
        .rstN       (rstN),
        .cmdValid   (cmdValid),
        .cmdWord    (cmdWord),
        .cmdReady   (cmdReady),
        .outTrigB   (outTrigB),
        .extTrigB   (extTrigB),
        .srCk       (srCk),
        .srIn       (srIn),
        .hold       (hold),
        .configDone (configDone),
        .trigOut    (trigOut)
    );

    always @(posedge Clk) cycle <= cycle + 1;

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////
    function automatic scWordT scWordOf(dacCodeT d0, dacCodeT d1, dacCodeT d2, headerT hdr);
        return {hdr, d2, d1, d0};   // Header goes out first
    endfunction

    function automatic logic trigLevelOf(trigModeT mode, logic [2:0] trigB, logic extB);
        logic [2:0] fired;
        fired = ~trigB;
        case (mode)
            trigSingle:   return fired[0];
            trigOr:       return |fired;
            trigAnd:      return &fired;
            trigExternal: return ~extB;
            default:      return 1'b0;
        endcase
    endfunction

    // Input change in cycle c, hold high from c+4+delay
    function automatic logic [63:0] holdStartCycle(logic [63:0] driveCyc, holdDelayT delay);
        return driveCyc + 64'(delay) + 4;
    endfunction

    function automatic logic [63:0] holdWidthCycles(logic en, holdTimeT width);
        return (en && width != '0) ? 64'(width) : 64'd0;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    task automatic checkValue(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            errorCount++;
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    task automatic abortOnTimeout(string what);
        errorCount++;
        $display("Timeout in test %s: %s never arrived", curTest, what);
        $display("Done: errors found");
        $finish;
    endtask

    task automatic nextCycle();
        @(posedge Clk);
        #1;                         // Drive and sample just after the edge
    endtask

    task automatic startTest(string name);
        curTest = name;
        testStartErrors = errorCount;
    endtask

    task automatic endTest();
        testCount++;
        if (errorCount != testStartErrors) begin
            failedTests++;
            $display("Test %s: FAILED, %0d errors", curTest, errorCount - testStartErrors);
        end else begin
            $display("Test %s: passed", curTest);
        end
    endtask

    // acceptCycle is the cycle whose closing edge transfers the word
    task automatic sendWord(cmdAddrT addr, cmdDataT data, output logic [63:0] acceptCycle);
        int waited;
        waited = 0;
        cmdValid = 1'b1;
        cmdWord  = {addr, data};
        while (!cmdReady) begin
            if (waited == 300) abortOnTimeout("cmdReady");
            waited++;
            nextCycle();
        end
        acceptCycle = cycle;
        nextCycle();
        cmdValid = 1'b0;
        cmdWord  = '0;
    endtask

    task automatic waitConfigDone(output logic [63:0] doneCyc);
        int waited;
        waited = 0;
        while (!configDone) begin
            if (waited == 300) abortOnTimeout("configDone");
            waited++;
            nextCycle();
        end
        doneCyc = cycle;
    endtask

    task automatic checkTrigPattern(trigModeT mode, logic [3:0] pattern);
        logic [63:0] driveCyc;
        logic [63:0] pulses;
        logic [63:0] pulseCyc;
        logic        expFire;
        expFire  = trigLevelOf(mode, pattern[2:0], pattern[3]);
        pulses   = '0;
        pulseCyc = '0;
        {extTrigB, outTrigB} = pattern;
        driveCyc = cycle;
        for (int i = 0; i < 8; i++) begin
            nextCycle();
            if (trigOut) begin
                pulses   = pulses + 1;
                pulseCyc = cycle;
            end
        end
        {extTrigB, outTrigB} = 4'b1111;
        checkValue($sformatf("%s mode %0d pattern %b pulses", curTest, mode, pattern),
                   expFire ? 64'd1 : 64'd0, pulses);
        if (expFire) begin
            checkValue($sformatf("%s mode %0d pattern %b cycle", curTest, mode, pattern),
                       driveCyc + 3, pulseCyc);
        end
        repeat (6) nextCycle();     // Synchronizer back to idle
    endtask

    // One trigger on line 0, optional retrigger while hold is high
    task automatic observeHold(input logic retrigger, output logic [63:0] driveCyc,
                               output logic [63:0] rises, output logic [63:0] riseCyc,
                               output logic [63:0] fallCyc, output logic [63:0] trigs);
        logic holdPrev;
        rises    = '0;
        riseCyc  = '0;
        fallCyc  = '0;
        trigs    = '0;
        holdPrev = hold;
        outTrigB = 3'b110;
        driveCyc = cycle;
        nextCycle();
        outTrigB = 3'b111;
        for (int i = 0; i < 320; i++) begin
            nextCycle();
            if (hold && !holdPrev) begin
                rises   = rises + 1;
                riseCyc = cycle;
            end
            if (!hold && holdPrev) fallCyc = cycle;
            holdPrev = hold;
            trigs    = trigs + 64'(trigOut);
            if (retrigger && rises == 1 && cycle == riseCyc + 2) outTrigB = 3'b110;
            if (retrigger && rises == 1 && cycle == riseCyc + 3) outTrigB = 3'b111;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Serial monitor, rising srCk samples srIn
    //////////////////////////////////////////////////////////////////////
    initial begin
        forever begin
            @(posedge Clk);
            #2;
            if (srCk && !srCkPrev) begin
                capWord   = {capWord[SC_WORD_BITS-2:0], srIn};
                srCkEdges = srCkEdges + 1;
            end
            srCkPrev = srCk;
            if (configDone) begin   // Whole word is in
                doneCount = doneCount + 1;
                checkValue({curTest, " serial word"}, 64'(expWord), 64'(capWord));
                checkValue({curTest, " srCk edges"}, 64'(SC_WORD_BITS), srCkEdges);
                srCkEdges = '0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////
    initial begin
        logic [63:0] acc;
        logic [63:0] loadAcc;
        logic [63:0] doneCyc;
        logic [63:0] prevDone;
        logic [63:0] driveCyc;
        logic [63:0] rises;
        logic [63:0] riseCyc;
        logic [63:0] fallCyc;
        logic [63:0] trigs;
        logic [31:0] rnd;
        dacCodeT     d0;
        dacCodeT     d1;
        dacCodeT     d2;
        headerT      hdr;
        holdDelayT   hDelay;
        holdTimeT    hTime;
        int          waited;

        rnd      = $urandom(32'hbd047a6c);
        cmdValid = 1'b0;
        cmdWord  = '0;
        outTrigB = 3'b111;          // All triggers idle
        extTrigB = 1'b1;

        waited = 0;
        while (rstN !== 1'b1) begin
            if (waited == 10) abortOnTimeout("reset release");
            waited++;
            nextCycle();
        end

        startTest("reset");
        checkValue("reset srCk", 64'd0, 64'(srCk));
        checkValue("reset srIn", 64'd0, 64'(srIn));
        checkValue("reset configDone", 64'd0, 64'(configDone));
        checkValue("reset trigOut", 64'd0, 64'(trigOut));
        checkValue("reset hold", 64'd0, 64'(hold));
        checkValue("reset cmdReady", 64'd1, 64'(cmdReady));
        endTest();

        startTest("scLoad");
        rnd = $urandom;
        d0  = rnd[9:0];
        d1  = rnd[19:10];
        d2  = rnd[29:20];
        rnd = $urandom;
        hdr = rnd[7:0];
        sendWord(ADDR_DAC0, {2'b00, d0}, acc);
        sendWord(ADDR_DAC1, {2'b00, d1}, acc);
        sendWord(ADDR_DAC2, {2'b00, d2}, acc);
        sendWord(ADDR_HEADER, {4'h0, hdr}, acc);
        expWord  = scWordOf(d0, d1, d2, hdr);
        prevDone = doneCount;
        sendWord(ADDR_LOAD, '0, loadAcc);
        waitConfigDone(doneCyc);
        checkValue("scLoad latency", loadAcc + 78, doneCyc);
        repeat (5) nextCycle();
        checkValue("scLoad done pulses", prevDone + 1, doneCount);
        endTest();

        startTest("backPressure");
        prevDone = doneCount;
        sendWord(ADDR_LOAD, '0, loadAcc);   // Same word again
        nextCycle();                        // Shift now running
        checkValue("backPressure stall", 64'd0, 64'(cmdReady));
        rnd = $urandom;
        d0  = d0 ^ (rnd[9:0] | 10'd1);      // Always a new code
        sendWord(ADDR_DAC0, {2'b00, d0}, acc);
        checkValue("backPressure accept", loadAcc + 78, acc);
        expWord = scWordOf(d0, d1, d2, hdr);
        sendWord(ADDR_LOAD, '0, loadAcc);
        waitConfigDone(doneCyc);
        checkValue("backPressure latency", loadAcc + 78, doneCyc);
        repeat (5) nextCycle();
        checkValue("backPressure done pulses", prevDone + 2, doneCount);
        endTest();

        startTest("coincidence");
        for (int m = 0; m < 4; m++) begin
            sendWord(ADDR_TRIG_MODE, {10'd0, trigModeT'(m[1:0])}, acc);
            repeat (2) nextCycle();
            for (int p = 0; p < 6; p++) begin
                checkTrigPattern(trigModeT'(m[1:0]), TRIG_PATTERNS[p]);
            end
        end
        endTest();

        startTest("holdTiming");
        rnd    = $urandom;
        hDelay = {3'b000, rnd[4:0]};
        hTime  = {4'h0, rnd[15:8]} + 12'd12;    // Long enough for a retrigger
        sendWord(ADDR_TRIG_MODE, {10'd0, trigOr}, acc);
        sendWord(ADDR_HOLD_EN, 12'd1, acc);
        sendWord(ADDR_HOLD_DELAY, {4'h0, hDelay}, acc);
        sendWord(ADDR_HOLD_TIME, hTime, acc);
        repeat (2) nextCycle();
        observeHold(1'b1, driveCyc, rises, riseCyc, fallCyc, trigs);
        checkValue("holdTiming rises", 64'd1, rises);
        checkValue("holdTiming start", holdStartCycle(driveCyc, hDelay), riseCyc);
        checkValue("holdTiming width", holdWidthCycles(1'b1, hTime), fallCyc - riseCyc);
        checkValue("holdTiming trigOut pulses", 64'd2, trigs);
        endTest();

        startTest("holdDisabled");
        sendWord(ADDR_HOLD_EN, 12'd0, acc);
        repeat (2) nextCycle();
        observeHold(1'b0, driveCyc, rises, riseCyc, fallCyc, trigs);
        checkValue("holdDisabled rises", holdWidthCycles(1'b0, hTime), rises);
        checkValue("holdDisabled trigOut pulses", 64'd1, trigs);
        endTest();

        $display("Summary: %0d tests, %0d failed, %0d errors",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
